//--- hw/chess_pkg.sv
`default_nettype none

package chess_pkg;

   typedef logic [3:0]   piece_t;   // bit 3 set for black
   typedef logic [255:0] board_t;   // square = row * 8 + col
   typedef logic signed [4:0] coord_t;

   localparam int BLACK_BIT = 3;

   localparam logic [2:0] PIECE_EMPTY = 3'd0;
   localparam logic [2:0] PIECE_PAWN  = 3'd1;
   localparam logic [2:0] PIECE_KNIGHT = 3'd2;
   localparam logic [2:0] PIECE_BISHOP = 3'd3;
   localparam logic [2:0] PIECE_ROOK  = 3'd4;
   localparam logic [2:0] PIECE_QUEEN = 3'd5;
   localparam logic [2:0] PIECE_KING  = 3'd6;

   typedef enum logic [2:0] {
      DIR_QUEEN,
      DIR_ROOK,
      DIR_BISHOP,
      DIR_KNIGHT,
      DIR_KING,
      DIR_PAWN
   } dir_kind_t;

   // pawn rows are for white and get negated for black
   // pawn order is double advance, left capture, single advance, right capture
   localparam coord_t DIR_ROW [0:5][0:7] = '{
      '{-1, -1, -1,  0,  0,  1,  1,  1},
      '{ 0,  0,  1, -1,  0,  0,  0,  0},
      '{ 1,  1, -1, -1,  0,  0,  0,  0},
      '{-2, -1,  1,  2,  2,  1, -1, -2},
      '{-1, -1, -1,  0,  0,  1,  1,  1},
      '{ 2,  1,  1,  1,  0,  0,  0,  0}
   };

   localparam coord_t DIR_COL [0:5][0:7] = '{
      '{-1,  0,  1, -1,  1, -1,  0,  1},
      '{ 1, -1,  0,  0,  0,  0,  0,  0},
      '{ 1, -1,  1, -1,  0,  0,  0,  0},
      '{-1, -2, -2, -1,  1,  2,  2,  1},
      '{-1,  0,  1, -1,  1, -1,  0,  1},
      '{ 0, -1,  0,  1,  0,  0,  0,  0}
   };

   localparam logic [3:0] DIR_COUNT [0:5] = '{4'd8, 4'd4, 4'd4, 4'd8, 4'd8, 4'd4};

   // indexed by white_to_move
   localparam coord_t PAWN_START_ROW [0:1] = '{5'sd6, 5'sd1};

endpackage

`default_nettype wire

//--- hw/movegen_pkg.sv
`default_nettype none

package movegen_pkg;

   localparam int MAX_MOVES  = 256;
   localparam int MOVE_IDX_W = 8;
   localparam int MOVE_CNT_W = 9;   // one more bit so a full RAM still counts

   // 258 bits, board in the upper bits
   typedef struct packed {
      chess_pkg::board_t board;
      logic              white_to_move;
      logic              capture;
   } move_rec_t;

endpackage

`default_nettype wire

//--- hw/move_write_if.sv
`timescale 1ns/10ps
`default_nettype none

interface move_write_if;

   logic              wr;
   chess_pkg::board_t board_after;
   logic              white_to_move;
   logic              capture;
   logic              clear;   // restarts the write counter

   modport builder (output wr, output board_after, output white_to_move, output capture);
   modport store (input wr, input board_after, input white_to_move, input capture,
                  input clear);
   modport ctrl (output clear);

endinterface

`default_nettype wire

//--- hw/move_offsets.sv
`timescale 1ns/10ps
`default_nettype none

module move_offsets (
   input  logic                 clk,
   input  chess_pkg::dir_kind_t step_kind,
   input  logic [2:0]           step_dir,
   input  chess_pkg::coord_t    step_from_row,
   input  chess_pkg::coord_t    step_from_col,
   input  logic                 step_req,
   input  logic                 white_to_move,
   output chess_pkg::coord_t    target_row,
   output chess_pkg::coord_t    target_col,
   output logic                 target_on_board,
   output logic [3:0]           dir_count
);

   chess_pkg::coord_t row_off;
   chess_pkg::coord_t col_off;
   chess_pkg::coord_t next_row;
   chess_pkg::coord_t next_col;
   logic              next_on_board;

   assign dir_count = chess_pkg::DIR_COUNT[step_kind];

   always_comb
   begin
      row_off = chess_pkg::DIR_ROW[step_kind][step_dir];
      col_off = chess_pkg::DIR_COL[step_kind][step_dir];
      if (step_kind == chess_pkg::DIR_PAWN && !white_to_move)
         row_off = -row_off;   // black pawns head down
      next_row = step_from_row + row_off;
      next_col = step_from_col + col_off;
      next_on_board = next_row >= 0 && next_row <= 7 && next_col >= 0 && next_col <= 7;
   end

   always_ff @(posedge clk)
   begin
      if (step_req)
      begin
         target_row      <= next_row;
         target_col      <= next_col;
         target_on_board <= next_on_board;
      end
   end

   a_dir_in_range: assert property (@(posedge clk)
      step_req |-> {1'b0, step_dir} < dir_count);

endmodule

`default_nettype wire

//--- hw/move_builder.sv
`timescale 1ns/10ps
`default_nettype none

module move_builder (
   input  logic              clk,
   input  logic              reset,
   input  logic              emit,
   input  logic [5:0]        from_sq,
   input  logic [5:0]        to_sq,
   input  chess_pkg::board_t board,
   input  logic              white_to_move,
   move_write_if.builder     wr_port
);

   chess_pkg::board_t next_board;
   chess_pkg::piece_t mover;
   logic              occupied;

   always_comb
   begin
      mover      = board[{from_sq, 2'b00} +: 4];
      occupied   = board[{to_sq, 2'b00} +: 3] != chess_pkg::PIECE_EMPTY;
      next_board = board;
      next_board[{from_sq, 2'b00} +: 4] = '0;
      next_board[{to_sq, 2'b00} +: 4]   = mover;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         wr_port.wr <= 1'b0;
      else
         wr_port.wr <= emit;
   end

   always_ff @(posedge clk)
   begin
      if (emit)
      begin
         wr_port.board_after   <= next_board;
         wr_port.white_to_move <= !white_to_move;   // other side moves next
         wr_port.capture       <= occupied;
      end
   end

endmodule

`default_nettype wire

//--- hw/move_store.sv
`timescale 1ns/10ps
`default_nettype none

module move_store (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [movegen_pkg::MOVE_IDX_W-1:0]  move_index,
   output logic [movegen_pkg::MOVE_CNT_W-1:0]  move_count,
   output logic                                move_ready,
   output movegen_pkg::move_rec_t              rd_rec,
   move_write_if.store                         wr_port
);

   movegen_pkg::move_rec_t             ram [movegen_pkg::MAX_MOVES];
   logic [movegen_pkg::MOVE_IDX_W-1:0] move_index_r;

   always_ff @(posedge clk)
   begin
      if (reset || wr_port.clear)
         move_count <= '0;
      else if (wr_port.wr)
         move_count <= move_count + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (wr_port.wr)
         ram[move_count[movegen_pkg::MOVE_IDX_W-1:0]] <= '{board: wr_port.board_after,
                                                          white_to_move: wr_port.white_to_move,
                                                          capture: wr_port.capture};
   end

   always_ff @(posedge clk)
   begin
      rd_rec       <= ram[move_index];
      move_index_r <= move_index;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         move_ready <= 1'b0;
      else
         move_ready <= move_index == move_index_r;   // index steady for a cycle
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      wr_port.wr |-> move_count != movegen_pkg::MAX_MOVES);

endmodule

`default_nettype wire

//--- hw/move_gen_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module move_gen_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 board_valid,
   input  chess_pkg::board_t    board_in,
   input  logic                 white_to_move_in,
   input  logic                 clear_moves,
   output chess_pkg::dir_kind_t step_kind,
   output logic [2:0]           step_dir,
   output chess_pkg::coord_t    step_from_row,
   output chess_pkg::coord_t    step_from_col,
   output logic                 step_req,
   input  chess_pkg::coord_t    target_row,
   input  chess_pkg::coord_t    target_col,
   input  logic                 target_on_board,
   input  logic [3:0]           dir_count,
   output logic                 emit,
   output logic [5:0]           from_sq,
   output logic [5:0]           to_sq,
   output chess_pkg::board_t    board,
   output logic                 white_to_move,
   output logic                 moves_ready,
   move_write_if.ctrl           wr_port
);

   typedef enum logic [2:0] {ST_IDLE, ST_SCAN, ST_STEP, ST_CHECK, ST_NEXT, ST_DONE} state_t;

   state_t            state;
   logic [5:0]        sq;
   logic              cont;   // slider carries on from the last target
   chess_pkg::piece_t sq_piece;
   chess_pkg::piece_t tgt_piece;
   chess_pkg::coord_t sq_row;
   chess_pkg::coord_t sq_col;
   logic [5:0]        mid_sq;
   logic              own_piece;
   logic              tgt_empty;
   logic              tgt_enemy;
   logic              mid_empty;
   logic              is_slider;
   logic              accept;
   logic              last_dir;

   assign sq_piece  = board[{sq, 2'b00} +: 4];
   assign tgt_piece = board[{target_row[2:0], target_col[2:0], 2'b00} +: 4];
   assign mid_sq    = white_to_move ? sq + 6'd8 : sq - 6'd8;
   assign sq_row    = chess_pkg::coord_t'({2'b00, sq[5:3]});
   assign sq_col    = chess_pkg::coord_t'({2'b00, sq[2:0]});

   assign own_piece = sq_piece[2:0] != chess_pkg::PIECE_EMPTY &&
                      sq_piece[2:0] <= chess_pkg::PIECE_KING &&
                      sq_piece[chess_pkg::BLACK_BIT] == !white_to_move;
   assign tgt_empty = tgt_piece[2:0] == chess_pkg::PIECE_EMPTY;
   assign tgt_enemy = !tgt_empty && tgt_piece[chess_pkg::BLACK_BIT] == white_to_move;
   assign mid_empty = board[{mid_sq, 2'b00} +: 3] == chess_pkg::PIECE_EMPTY;
   assign is_slider = step_kind inside {chess_pkg::DIR_QUEEN, chess_pkg::DIR_ROOK,
                                        chess_pkg::DIR_BISHOP};
   assign last_dir  = {1'b0, step_dir} == dir_count - 4'd1;

   always_comb
   begin
      if (step_kind == chess_pkg::DIR_PAWN)
         case (step_dir)
            3'd0:    accept = target_on_board && tgt_empty && mid_empty;
            3'd2:    accept = target_on_board && tgt_empty;
            default: accept = target_on_board && tgt_enemy;   // diagonals
         endcase
      else
         accept = target_on_board && (tgt_empty || tgt_enemy);
   end

   assign step_req      = state == ST_STEP;
   assign step_from_row = cont ? target_row : sq_row;
   assign step_from_col = cont ? target_col : sq_col;
   assign emit          = state == ST_CHECK && accept;
   assign from_sq       = sq;
   assign to_sq         = {target_row[2:0], target_col[2:0]};

   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && board_valid)
      begin
         board         <= board_in;
         white_to_move <= white_to_move_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= ST_IDLE;
         sq            <= '0;
         cont          <= 1'b0;
         step_dir      <= '0;
         step_kind     <= chess_pkg::DIR_QUEEN;
         moves_ready   <= 1'b0;
         wr_port.clear <= 1'b0;
      end
      else
      begin
         wr_port.clear <= state == ST_IDLE && board_valid;
         case (state)
            ST_IDLE:
            begin
               moves_ready <= 1'b0;
               sq          <= '0;
               if (board_valid)
                  state <= ST_SCAN;
            end
            ST_SCAN:
            begin
               cont <= 1'b0;
               if (own_piece)
               begin
                  case (sq_piece[2:0])
                     chess_pkg::PIECE_PAWN:   step_kind <= chess_pkg::DIR_PAWN;
                     chess_pkg::PIECE_KNIGHT: step_kind <= chess_pkg::DIR_KNIGHT;
                     chess_pkg::PIECE_BISHOP: step_kind <= chess_pkg::DIR_BISHOP;
                     chess_pkg::PIECE_ROOK:   step_kind <= chess_pkg::DIR_ROOK;
                     chess_pkg::PIECE_QUEEN:  step_kind <= chess_pkg::DIR_QUEEN;
                     default:                 step_kind <= chess_pkg::DIR_KING;
                  endcase
                  // no double advance off the start row
                  if (sq_piece[2:0] == chess_pkg::PIECE_PAWN &&
                      sq_row != chess_pkg::PAWN_START_ROW[white_to_move])
                     step_dir <= 3'd1;
                  else
                     step_dir <= 3'd0;
                  state <= ST_STEP;
               end
               else if (sq == 6'd63)
                  state <= ST_DONE;
               else
                  sq <= sq + 6'd1;
            end
            ST_STEP:
               state <= ST_CHECK;   // offsets answer next cycle
            ST_CHECK:
            begin
               if (is_slider && target_on_board && tgt_empty)
               begin
                  cont  <= 1'b1;
                  state <= ST_STEP;
               end
               else if (last_dir)
                  state <= ST_NEXT;
               else
               begin
                  cont     <= 1'b0;
                  step_dir <= step_dir + 3'd1;
                  state    <= ST_STEP;
               end
            end
            ST_NEXT:
            begin
               if (sq == 6'd63)
                  state <= ST_DONE;
               else
               begin
                  sq    <= sq + 6'd1;
                  state <= ST_SCAN;
               end
            end
            ST_DONE:
            begin
               moves_ready <= !clear_moves;
               if (clear_moves)
                  state <= ST_IDLE;
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   a_state_valid: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(state) && state inside {ST_IDLE, ST_SCAN, ST_STEP, ST_CHECK, ST_NEXT, ST_DONE});

endmodule

`default_nettype wire

//--- hw/move_gen_top.sv
`timescale 1ns/10ps
`default_nettype none

module move_gen_top (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                board_valid,
   input  chess_pkg::board_t                   board_in,
   input  logic                                white_to_move_in,
   input  logic                                clear_moves,
   input  logic [movegen_pkg::MOVE_IDX_W-1:0]  move_index,
   output logic                                moves_ready,
   output logic                                move_ready,
   output logic [movegen_pkg::MOVE_CNT_W-1:0]  move_count,
   output chess_pkg::board_t                   board_out,
   output logic                                white_to_move_out,
   output logic                                capture_out
);

   chess_pkg::dir_kind_t   step_kind;
   logic [2:0]             step_dir;
   chess_pkg::coord_t      step_from_row;
   chess_pkg::coord_t      step_from_col;
   logic                   step_req;
   chess_pkg::coord_t      target_row;
   chess_pkg::coord_t      target_col;
   logic                   target_on_board;
   logic [3:0]             dir_count;
   logic                   emit;
   logic [5:0]             from_sq;
   logic [5:0]             to_sq;
   chess_pkg::board_t      board;
   logic                   white_to_move;
   movegen_pkg::move_rec_t rd_rec;

   move_write_if mw ();

   assign board_out         = rd_rec.board;
   assign white_to_move_out = rd_rec.white_to_move;
   assign capture_out       = rd_rec.capture;

   move_gen_ctrl u_ctrl (
      .clk, .reset, .board_valid, .board_in, .white_to_move_in, .clear_moves,
      .step_kind, .step_dir, .step_from_row, .step_from_col, .step_req,
      .target_row, .target_col, .target_on_board, .dir_count,
      .emit, .from_sq, .to_sq, .board, .white_to_move, .moves_ready,
      .wr_port (mw.ctrl)
   );

   move_offsets u_offsets (
      .clk, .step_kind, .step_dir, .step_from_row, .step_from_col, .step_req,
      .white_to_move, .target_row, .target_col, .target_on_board, .dir_count
   );

   move_builder u_builder (
      .clk, .reset, .emit, .from_sq, .to_sq, .board, .white_to_move,
      .wr_port (mw.builder)
   );

   move_store u_store (
      .clk, .reset, .move_index, .move_count, .move_ready, .rd_rec,
      .wr_port (mw.store)
   );

endmodule

`default_nettype wire

//--- dv/tb_chess_model.svh
`ifndef TB_CHESS_MODEL_SVH
`define TB_CHESS_MODEL_SVH

// expected moves in scan order
chess_pkg::board_t exp_board [movegen_pkg::MAX_MOVES];
logic              exp_capture [movegen_pkg::MAX_MOVES];
int                exp_count;

int rook_dr [4]   = '{0, 0, 1, -1};
int rook_dc [4]   = '{1, -1, 0, 0};
int bishop_dr [4] = '{1, 1, -1, -1};
int bishop_dc [4] = '{1, -1, 1, -1};
int knight_dr [8] = '{-2, -1, 1, 2, 2, 1, -1, -2};
int knight_dc [8] = '{-1, -2, -2, -1, 1, 2, 2, 1};

function automatic chess_pkg::piece_t piece_at(input chess_pkg::board_t b, input int r,
                                               input int c);
   return b[(r * 8 + c) * 4 +: 4];
endfunction

// -1 off board, 0 empty, 1 own piece, 2 opponent piece
function automatic int occupant(input chess_pkg::board_t b, input int r, input int c,
                                input logic wtm);
   chess_pkg::piece_t p;
   if (r < 0 || r > 7 || c < 0 || c > 7)
      return -1;
   p = piece_at(b, r, c);
   if (p[2:0] == chess_pkg::PIECE_EMPTY)
      return 0;
   return (p[chess_pkg::BLACK_BIT] == !wtm) ? 1 : 2;
endfunction

task automatic add_move(input chess_pkg::board_t b, input int fr, input int fc,
                        input int tr, input int tc);
   chess_pkg::board_t after;
   chess_pkg::piece_t victim;
   after  = b;
   victim = piece_at(b, tr, tc);
   after[(fr * 8 + fc) * 4 +: 4] = 4'h0;
   after[(tr * 8 + tc) * 4 +: 4] = piece_at(b, fr, fc);
   if (exp_count < movegen_pkg::MAX_MOVES)
   begin
      exp_board[exp_count]   = after;
      exp_capture[exp_count] = victim[2:0] != chess_pkg::PIECE_EMPTY;
   end
   exp_count++;
endtask

task automatic get_step(input logic [2:0] kind, input int d, output int dr, output int dc);
   int k;
   case (kind)
      chess_pkg::PIECE_ROOK:
      begin
         dr = rook_dr[d];
         dc = rook_dc[d];
      end
      chess_pkg::PIECE_BISHOP:
      begin
         dr = bishop_dr[d];
         dc = bishop_dc[d];
      end
      chess_pkg::PIECE_KNIGHT:
      begin
         dr = knight_dr[d];
         dc = knight_dc[d];
      end
      default:
      begin
         k  = (d < 4) ? d : d + 1;   // queen and king skip the zero step
         dr = k / 3 - 1;
         dc = k % 3 - 1;
      end
   endcase
endtask

task automatic build_expected(input chess_pkg::board_t b, input logic wtm);
   chess_pkg::piece_t p;
   int sq;
   int r;
   int c;
   int d;
   int dr;
   int dc;
   int tr;
   int tc;
   int fwd;
   int ndirs;
   logic slide;
   exp_count = 0;
   fwd = wtm ? 1 : -1;
   for (sq = 0; sq < 64; sq++)
   begin
      r = sq / 8;
      c = sq % 8;
      p = piece_at(b, r, c);
      if (occupant(b, r, c, wtm) == 1 && p[2:0] == chess_pkg::PIECE_PAWN)
      begin
         if (r == (wtm ? 1 : 6) && occupant(b, r + fwd, c, wtm) == 0 &&
             occupant(b, r + 2 * fwd, c, wtm) == 0)
            add_move(b, r, c, r + 2 * fwd, c);
         if (occupant(b, r + fwd, c - 1, wtm) == 2)
            add_move(b, r, c, r + fwd, c - 1);
         if (occupant(b, r + fwd, c, wtm) == 0)
            add_move(b, r, c, r + fwd, c);
         if (occupant(b, r + fwd, c + 1, wtm) == 2)
            add_move(b, r, c, r + fwd, c + 1);
      end
      else if (occupant(b, r, c, wtm) == 1)
      begin
         ndirs = (p[2:0] inside {chess_pkg::PIECE_ROOK, chess_pkg::PIECE_BISHOP}) ? 4 : 8;
         slide = p[2:0] inside {chess_pkg::PIECE_ROOK, chess_pkg::PIECE_BISHOP,
                                chess_pkg::PIECE_QUEEN};
         for (d = 0; d < ndirs; d++)
         begin
            get_step(p[2:0], d, dr, dc);
            tr = r + dr;
            tc = c + dc;
            while (slide && occupant(b, tr, tc, wtm) == 0)
            begin
               add_move(b, r, c, tr, tc);
               tr = tr + dr;
               tc = tc + dc;
            end
            if (occupant(b, tr, tc, wtm) == 0 || occupant(b, tr, tc, wtm) == 2)
               add_move(b, r, c, tr, tc);   // sliders only end here on a capture
         end
      end
   end
endtask

`endif

//--- dv/tb_move_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_move_gen;

   localparam int GEN_LIMIT  = 20000;   // cycles
   localparam int READ_LIMIT = 8;

   typedef logic [movegen_pkg::MOVE_CNT_W-1:0] count_t;
   typedef logic [movegen_pkg::MOVE_IDX_W-1:0] idx_t;

   logic              clk;
   logic              reset;
   logic              board_valid;
   chess_pkg::board_t board_in;
   logic              white_to_move_in;
   logic              clear_moves;
   idx_t              move_index;
   logic              moves_ready;
   logic              move_ready;
   count_t            move_count;
   chess_pkg::board_t board_out;
   logic              white_to_move_out;
   logic              capture_out;

   logic [31:0] rng;
   logic        cur_wtm;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          errors_at_start;

   `include "tb_chess_model.svh"

   move_gen_top dut (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic chess_pkg::board_t place(input chess_pkg::board_t b, input int r,
                                               input int c, input chess_pkg::piece_t p);
      chess_pkg::board_t nb;
      nb = b;
      nb[(r * 8 + c) * 4 +: 4] = p;
      return nb;
   endfunction

   task automatic random_board(output chess_pkg::board_t b);
      logic [2:0] kind;
      int sq;
      b = '0;
      for (sq = 0; sq < 64; sq++)
      begin
         rng = xorshift32(rng);
         if (rng[0])
         begin
            kind = 3'(rng[15:8] % 8'd6) + 3'd1;
            if (kind == chess_pkg::PIECE_PAWN && (sq < 8 || sq >= 56))
               kind = chess_pkg::PIECE_KNIGHT;   // no pawns on the back ranks
            b[sq * 4 +: 4] = {rng[20], kind};
         end
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $finish;
   endtask

   task automatic check_board(input string name, input chess_pkg::board_t got,
                              input chess_pkg::board_t exp);
      checks++;
      if (got !== exp)
      begin
         $display("Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         $display("Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(input string name, input count_t got, input count_t exp);
      checks++;
      if (got !== exp)
      begin
         $display("Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic wait_moves_ready(input logic level);
      int cycles;
      cycles = 0;
      while (moves_ready !== level && cycles < GEN_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (moves_ready !== level)
         abort_run($sformatf("timeout waiting for moves_ready to become %0d", level));
   endtask

   task automatic start_generation(input chess_pkg::board_t b, input logic wtm);
      build_expected(b, wtm);
      cur_wtm          = wtm;
      board_in         = b;
      white_to_move_in = wtm;
      board_valid      = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      wait_moves_ready(1'b1);
      check_count("move_count", move_count, count_t'(exp_count));
   endtask

   task automatic read_and_check(input int idx);
      int cycles;
      move_index = idx_t'(idx);
      cycles = 1;
      @(negedge clk);
      while (!move_ready && cycles < READ_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!move_ready)
         abort_run("move_ready stayed low while move_index was held");
      check_board("board_out", board_out, exp_board[idx]);
      check_flag("white_to_move_out", white_to_move_out, !cur_wtm);
      check_flag("capture_out", capture_out, exp_capture[idx]);
   endtask

   task automatic clear_generation();
      clear_moves = 1'b1;
      @(negedge clk);
      clear_moves = 1'b0;
      wait_moves_ready(1'b0);
   endtask

   task automatic run_position(input chess_pkg::board_t b, input logic wtm);
      int i;
      start_generation(b, wtm);
      for (i = 0; i < exp_count && i < movegen_pkg::MAX_MOVES; i++)
         read_and_check(i);
      clear_generation();
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errors_at_start)
         $display("test %0d %s: passed", tests_run, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: failed, %0d errors", tests_run, name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   initial
   begin
      chess_pkg::board_t b;
      int i;
      int idx;
      clk              = 1'b0;
      reset            = 1'b1;
      board_valid      = 1'b0;
      board_in         = '0;
      white_to_move_in = 1'b0;
      clear_moves      = 1'b0;
      move_index       = '0;
      rng              = 32'd77;
      cur_wtm          = 1'b0;
      errors           = 0;
      checks           = 0;
      tests_run        = 0;
      tests_failed     = 0;
      errors_at_start  = 0;
      idx              = 0;
      repeat (8) @(negedge clk);

      check_flag("moves_ready", moves_ready, 1'b0);
      check_flag("move_ready", move_ready, 1'b0);
      reset = 1'b0;
      run_position('0, 1'b1);
      b = place('0, 7, 4, 4'hE);   // black only, white to move
      b = place(b, 6, 0, 4'h9);
      run_position(b, 1'b1);
      end_test("reset and empty");

      run_position(place('0, 3, 4, 4'h2), 1'b1);
      run_position(place('0, 0, 0, 4'h6), 1'b1);
      run_position(place('0, 2, 5, 4'h4), 1'b1);
      run_position(place('0, 4, 1, 4'hB), 1'b0);
      run_position(place('0, 3, 3, 4'hD), 1'b0);
      end_test("lone pieces");

      b = place('0, 1, 2, 4'h1);
      run_position(b, 1'b1);
      run_position(place(b, 3, 2, 4'hA), 1'b1);   // double target taken
      b = place(b, 2, 2, 4'hA);
      b = place(b, 2, 1, 4'hA);
      b = place(b, 2, 3, 4'h2);   // own piece on the right diagonal
      run_position(b, 1'b1);
      b = place('0, 4, 4, 4'h1);
      b = place(b, 5, 3, 4'h9);
      b = place(b, 5, 5, 4'hC);
      run_position(b, 1'b1);
      b = place('0, 6, 5, 4'h9);
      run_position(b, 1'b0);
      b = place(b, 5, 4, 4'h2);
      b = place(b, 5, 6, 4'hA);
      run_position(b, 1'b0);
      run_position(place(place('0, 6, 2, 4'h9), 4, 2, 4'h3), 1'b0);
      end_test("pawns");

      for (i = 0; i < 200; i++)
      begin
         random_board(b);
         run_position(b, (i % 2) == 0);
      end
      end_test("random positions");

      random_board(b);
      b = place(b, 3, 3, 4'h5);
      b = place(b, 4, 3, 4'h0);   // queen has at least one move
      start_generation(b, 1'b1);
      for (i = 0; i < 40; i++)
      begin
         rng = xorshift32(rng);
         idx = int'(rng % 32'(exp_count));
         read_and_check(idx);
      end
      repeat (3)
      begin
         @(negedge clk);
         check_flag("move_ready", move_ready, 1'b1);
         check_board("board_out", board_out, exp_board[idx]);
      end
      clear_generation();
      run_position(place('0, 1, 0, 4'h1), 1'b1);   // count starts from zero again
      end_test("random read and clear");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+dv
hw/chess_pkg.sv
hw/movegen_pkg.sv
hw/move_write_if.sv
hw/move_offsets.sv
hw/move_builder.sv
hw/move_store.sv
hw/move_gen_ctrl.sv
hw/move_gen_top.sv
dv/tb_move_gen.sv

//--- run.sh
#!/bin/sh
# compile and run the move generator testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_move_gen -o sim_move_gen
out=$(./obj_dir/sim_move_gen || true)
echo "$out"
echo "$out" | grep -q "^Everything OK$"
